// File: pitch_interp.f
rtl/pitch_pkg.sv
rtl/g729_basic_ops.sv
rtl/inter3_rom.sv
rtl/excitation_ram.sv
rtl/pred_lt3_interp.sv
rtl/pitch_axil_regs.sv
rtl/pitch_interp_top.sv
sim/pitch_interp_tb.sv

// File: rtl/excitation_ram.sv
`default_nettype none

module excitation_ram #(
	parameter int ADDR_W = pitch_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic [ADDR_W-1:0] a_addr,
	input  wire pitch_pkg::sample_t a_wdata,
	input  wire logic a_we,
	output pitch_pkg::sample_t a_rdata,
	input  wire logic [ADDR_W-1:0] b_addr,
	input  wire pitch_pkg::sample_t b_wdata,
	input  wire logic b_we,
	input  wire logic b_re,
	output pitch_pkg::sample_t b_rdata
);
	import pitch_pkg::*;

	sample_t mem [2**ADDR_W];

	// both ports read the old word when writing
	always_ff @(posedge clk)
	begin
		a_rdata <= mem[a_addr];	// engine port reads every cycle
		if (a_we)
			mem[a_addr] <= a_wdata;
		if (b_re)
			b_rdata <= mem[b_addr];	// host port holds data between reads
		if (b_we)
			mem[b_addr] <= b_wdata;
	end

	// host window is locked while the engine writes
	no_write_collision: assert property (@(posedge clk)
		!(a_we && b_we && a_addr == b_addr))
		else $error("excitation_ram both ports write address %0d", a_addr);

endmodule

`default_nettype wire

// File: rtl/g729_basic_ops.sv
`default_nettype none

module g729_basic_ops (
	input  wire pitch_pkg::ops_req_t req,
	output pitch_pkg::ops_rsp_t rsp
);
	import pitch_pkg::*;

	acc_t prod;
	acc_t l_mult;

	function automatic sample_t sat16(input logic signed [16:0] v);
		if (v > 17'sd32767)
			return 16'sh7fff;
		if (v < -17'sd32768)
			return 16'sh8000;
		return v[15:0];
	endfunction

	function automatic acc_t sat32(input logic signed [32:0] v);
		if (v > 33'sd2147483647)
			return 32'sh7fff_ffff;
		if (v < -33'sd2147483648)
			return 32'sh8000_0000;
		return v[31:0];
	endfunction

	// L_mult doubles the Q15 product
	// only -32768 * -32768 overflows on the doubling
	assign prod = req.mac_a * req.mac_b;
	assign l_mult = (prod == 32'sh4000_0000) ? 32'sh7fff_ffff : (prod <<< 1);

	always_comb
	begin
		rsp.add_out = sat16(17'(req.add_a) + 17'(req.add_b));
		rsp.sub_out = sat16(17'(req.sub_a) - 17'(req.sub_b));
		rsp.mac_out = sat32(33'(req.mac_c) + 33'(l_mult));	// L_mac
		rsp.ladd_out = sat32(33'(req.ladd_a) + 33'(req.ladd_b));
		rsp.neg_out = (req.neg_in == 16'sh8000) ? 16'sh7fff : -req.neg_in;
	end

endmodule

`default_nettype wire

// File: rtl/inter3_rom.sv
`default_nettype none

module inter3_rom (
	input  wire logic clk,
	input  wire pitch_pkg::coef_addr_t addr,
	output pitch_pkg::sample_t data
);
	import pitch_pkg::*;

	// 1/3 resolution interpolation filter in Q15
	// phase p uses entries p, p+3, p+6 ...
	localparam sample_t INTER_3L [31] = '{
		16'sd29443, 16'sd25207, 16'sd14701, 16'sd3143, -16'sd4402, -16'sd5850,
		-16'sd2783, 16'sd1211, 16'sd3130, 16'sd2259, 16'sd0, -16'sd1652,
		-16'sd1666, -16'sd464, 16'sd756, 16'sd1099, 16'sd550, -16'sd245,
		-16'sd634, -16'sd451, 16'sd0, 16'sd308, 16'sd296, 16'sd78,
		-16'sd120, -16'sd165, -16'sd79, 16'sd34, 16'sd91, 16'sd70,
		16'sd0
	};

	always_ff @(posedge clk)
		data <= INTER_3L[addr];	// one cycle lookup

	// engine keeps c + k within the table
	rom_addr_range: assert property (@(posedge clk) addr < 5'd31)
		else $error("inter3_rom address %0d out of range", addr);

endmodule

`default_nettype wire

// File: rtl/pitch_axil_regs.sv
`default_nettype none

module pitch_axil_regs #(
	parameter int ADDR_W = pitch_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic [pitch_pkg::AXI_ADDR_W-1:0] awaddr,
	input  wire logic awvalid,
	output logic awready,
	input  wire logic [31:0] wdata,
	input  wire logic [3:0] wstrb,
	input  wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  wire logic bready,
	input  wire logic [pitch_pkg::AXI_ADDR_W-1:0] araddr,
	input  wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  wire logic rready,
	output logic start,
	output pitch_pkg::sample_t t0,
	output logic signed [1:0] frac,
	output logic [ADDR_W-1:0] base,
	output pitch_pkg::sample_t len,
	input  wire logic busy,
	input  wire logic done,
	output logic [ADDR_W-1:0] ram_addr,
	output pitch_pkg::sample_t ram_wdata,
	output logic ram_we,
	output logic ram_re,
	input  wire pitch_pkg::sample_t ram_rdata
);
	import pitch_pkg::*;

	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic wr_go;
	logic wr_hs;
	logic wr_win;
	logic rd_go;
	logic rd_pend;	// cycle the buffer is read
	logic rd_win;
	logic rd_win_ok;
	logic done_flag;
	logic [AXI_ADDR_W-1:0] rd_addr;
	logic [31:0] rdata_q;

	// reads and writes take turns so port B sees one access per cycle
	assign wr_go = !awready && awvalid && wvalid && !bvalid && !arready && !rd_pend;
	assign rd_go = !arready && arvalid && !rvalid && !rd_pend && !wr_go && !awready;
	assign wr_hs = awvalid && awready && wvalid;
	assign wready = awready;
	assign wr_win = (awaddr >= EXC_WINDOW);
	assign rd_win = (rd_addr >= EXC_WINDOW);

	//////////////////////////////////////////////////////////////////////
	// port B of the excitation buffer

	assign ram_we = wr_hs && wr_win && !busy && (wstrb == 4'hf);
	assign ram_re = rd_pend && rd_win && !busy;
	assign ram_addr = wr_hs ? awaddr[ADDR_W+1:2] : rd_addr[ADDR_W+1:2];
	assign ram_wdata = wdata[15:0];
	assign rdata = rd_win_ok ? 32'(ram_rdata) : rdata_q;	// sign extended sample

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= OKAY;
			rvalid <= 1'b0;
			rresp <= OKAY;
			rd_pend <= 1'b0;
			rd_win_ok <= 1'b0;
			start <= 1'b0;
			done_flag <= 1'b0;
			t0 <= '0;
			frac <= '0;
			base <= '0;
			len <= '0;
		end
		else
		begin
			awready <= wr_go;
			arready <= rd_go;
			start <= 1'b0;
			if (done)
				done_flag <= 1'b1;	// sticky until the next start
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_hs)
			begin
				bvalid <= 1'b1;
				bresp <= (wstrb != 4'hf || (wr_win && busy)) ? SLVERR : OKAY;
				// parameters and start are frozen during a job
				if (wstrb == 4'hf && !busy)
				begin
					case (awaddr)
						REG_CTRL:
						begin
							start <= wdata[0];
							if (wdata[0])
								done_flag <= 1'b0;
						end
						REG_T0: t0 <= wdata[15:0];
						REG_FRAC: frac <= wdata[1:0];
						REG_BASE: base <= wdata[ADDR_W-1:0];
						REG_LEN: len <= wdata[15:0];
						default: ;
					endcase
				end
			end
			rd_pend <= arready && arvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_pend)
			begin
				rvalid <= 1'b1;
				rresp <= (rd_win && busy) ? SLVERR : OKAY;
				rd_win_ok <= rd_win && !busy;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (arready && arvalid)
			rd_addr <= araddr;
		if (rd_pend)
		begin
			case (rd_addr)
				REG_CTRL: rdata_q <= {30'd0, done_flag, busy};
				REG_T0: rdata_q <= 32'(t0);
				REG_FRAC: rdata_q <= 32'(frac);
				REG_BASE: rdata_q <= 32'(base);
				REG_LEN: rdata_q <= 32'(len);
				default: rdata_q <= '0;	// window and unmapped
			endcase
		end
	end

	b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));
	r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// File: rtl/pitch_interp_top.sv
`default_nettype none

module pitch_interp_top #(
	parameter int ADDR_W = pitch_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic [pitch_pkg::AXI_ADDR_W-1:0] awaddr,
	input  wire logic awvalid,
	output logic awready,
	input  wire logic [31:0] wdata,
	input  wire logic [3:0] wstrb,
	input  wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  wire logic bready,
	input  wire logic [pitch_pkg::AXI_ADDR_W-1:0] araddr,
	input  wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  wire logic rready
);
	import pitch_pkg::*;

	// job parameters and handshake
	logic start;
	sample_t t0;
	logic signed [1:0] frac;
	logic [ADDR_W-1:0] base;
	sample_t len;
	logic busy;
	logic done;

	// engine datapath
	ops_req_t ops;
	ops_rsp_t ops_res;
	logic [ADDR_W-1:0] exc_addr;
	sample_t exc_wdata;
	logic exc_we;
	sample_t exc_rdata;
	coef_addr_t coef_addr;
	sample_t coef_data;

	// host side of the buffer
	logic [ADDR_W-1:0] ram_addr;
	sample_t ram_wdata;
	logic ram_we;
	logic ram_re;
	sample_t ram_rdata;

	pitch_axil_regs #(.ADDR_W(ADDR_W)) u_regs (.*);

	pred_lt3_interp #(.ADDR_W(ADDR_W)) u_engine (.*);

	g729_basic_ops u_ops (
		.req(ops),
		.rsp(ops_res)
	);

	inter3_rom u_rom (
		.clk(clk),
		.addr(coef_addr),
		.data(coef_data)
	);

	excitation_ram #(.ADDR_W(ADDR_W)) u_exc (
		.clk(clk),
		.a_addr(exc_addr),
		.a_wdata(exc_wdata),
		.a_we(exc_we),
		.a_rdata(exc_rdata),
		.b_addr(ram_addr),
		.b_wdata(ram_wdata),
		.b_we(ram_we),
		.b_re(ram_re),
		.b_rdata(ram_rdata)
	);

endmodule

`default_nettype wire

// File: rtl/pitch_pkg.sv
`default_nettype none

package pitch_pkg;

	localparam int ADDR_W = 8;	// excitation buffer holds 2**ADDR_W words
	localparam int AXI_ADDR_W = 12;
	localparam int N_TAPS = 10;
	localparam int UP_SAMP = 3;

	typedef logic signed [15:0] sample_t;	// excitation sample or Q15 coefficient
	typedef logic signed [31:0] acc_t;	// Q31 accumulator
	typedef logic [ADDR_W-1:0] exc_addr_t;
	typedef logic [4:0] coef_addr_t;

	// host register map, byte offsets
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_T0 = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_FRAC = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] REG_BASE = 12'h00c;
	localparam logic [AXI_ADDR_W-1:0] REG_LEN = 12'h010;
	localparam logic [AXI_ADDR_W-1:0] EXC_WINDOW = 12'h400;	// one word per sample

	// operands for the shared operator block
	typedef struct packed {
		sample_t add_a;
		sample_t add_b;
		sample_t sub_a;
		sample_t sub_b;
		sample_t mac_a;
		sample_t mac_b;
		acc_t mac_c;
		acc_t ladd_a;
		acc_t ladd_b;
		sample_t neg_in;
	} ops_req_t;

	typedef struct packed {
		sample_t add_out;
		sample_t sub_out;
		acc_t mac_out;
		acc_t ladd_out;
		sample_t neg_out;
	} ops_rsp_t;

	typedef enum logic [3:0] {
		IDLE,
		SETUP,
		ADJUST,
		SAMPLE,
		COEF1,
		COEF2,
		TAP_ADDR,
		TAP_NEG,
		TAP_POS,
		NEXT_SAMPLE
	} interp_state_e;

endpackage

`default_nettype wire

// File: rtl/pred_lt3_interp.sv
`default_nettype none

module pred_lt3_interp #(
	parameter int ADDR_W = pitch_pkg::ADDR_W
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic start,
	input  wire pitch_pkg::sample_t t0,
	input  wire logic signed [1:0] frac,
	input  wire logic [ADDR_W-1:0] base,
	input  wire pitch_pkg::sample_t len,
	output logic busy,
	output logic done,
	output pitch_pkg::ops_req_t ops,
	input  wire pitch_pkg::ops_rsp_t ops_res,
	output logic [ADDR_W-1:0] exc_addr,
	output pitch_pkg::sample_t exc_wdata,
	output logic exc_we,
	input  wire pitch_pkg::sample_t exc_rdata,
	output pitch_pkg::coef_addr_t coef_addr,
	input  wire pitch_pkg::sample_t coef_data
);
	import pitch_pkg::*;

	typedef struct packed {
		sample_t x0;	// lag pointer, advances per sample
		sample_t x1;	// left taps walk down from here
		sample_t x2;	// right taps walk up from here
		sample_t frac1;
		sample_t c1;
		sample_t c2;
		sample_t i;
		sample_t j;
		sample_t k;
		acc_t s;
	} engine_regs_t;

	interp_state_e state;
	interp_state_e state_nx;
	engine_regs_t r;
	engine_regs_t r_nx;

	assign busy = (state != IDLE);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_nx;
		r <= r_nx;	// datapath registers
	end

	//////////////////////////////////////////////////////////////////////
	// one operator group per control cycle

	always_comb
	begin
		state_nx = state;
		r_nx = r;
		ops = '0;
		done = 1'b0;
		exc_addr = '0;
		exc_wdata = '0;
		exc_we = 1'b0;
		coef_addr = '0;
		case (state)
			IDLE:
			begin
				r_nx.i = '0;
				r_nx.j = '0;
				r_nx.k = '0;
				if (start)
					state_nx = SETUP;
			end
			SETUP:
			begin
				ops.sub_a = sample_t'(base);
				ops.sub_b = t0;
				r_nx.x0 = ops_res.sub_out;	// x0 = &exc[-t0]
				ops.neg_in = sample_t'(frac);
				r_nx.frac1 = ops_res.neg_out;
				state_nx = ADJUST;
			end
			ADJUST:
			begin
				// negative fraction borrows one sample
				if (r.frac1 < 0)
				begin
					ops.add_a = r.frac1;
					ops.add_b = sample_t'(UP_SAMP);
					r_nx.frac1 = ops_res.add_out;
					ops.sub_a = r.x0;
					ops.sub_b = 16'sd1;
					r_nx.x0 = ops_res.sub_out;
				end
				state_nx = SAMPLE;
			end
			SAMPLE:
			begin
				if (r.j < len)
				begin
					ops.add_a = r.x0;
					ops.add_b = 16'sd1;
					r_nx.x1 = r.x0;
					r_nx.x2 = ops_res.add_out;
					r_nx.x0 = ops_res.add_out;
					state_nx = COEF1;
				end
				else
				begin
					done = 1'b1;
					state_nx = IDLE;
				end
			end
			COEF1:
			begin
				r_nx.c1 = r.frac1;	// left phase
				state_nx = COEF2;
			end
			COEF2:
			begin
				ops.sub_a = sample_t'(UP_SAMP);
				ops.sub_b = r.frac1;
				r_nx.c2 = ops_res.sub_out;	// right phase
				r_nx.s = '0;
				state_nx = TAP_ADDR;
			end
			TAP_ADDR:
			begin
				if (r.i < N_TAPS)
				begin
					ops.sub_a = r.x1;
					ops.sub_b = r.i;
					exc_addr = ops_res.sub_out[ADDR_W-1:0];	// x1[-i]
					ops.add_a = r.c1;
					ops.add_b = r.k;
					coef_addr = ops_res.add_out[4:0];
					state_nx = TAP_NEG;
				end
				else
				begin
					// round the Q31 sum back to a sample in place
					ops.ladd_a = r.s;
					ops.ladd_b = 32'sh0000_8000;
					ops.add_a = sample_t'(base);
					ops.add_b = r.j;
					exc_addr = ops_res.add_out[ADDR_W-1:0];
					exc_wdata = ops_res.ladd_out[31:16];
					exc_we = 1'b1;
					r_nx.i = '0;
					r_nx.k = '0;
					state_nx = NEXT_SAMPLE;
				end
			end
			TAP_NEG:
			begin
				ops.mac_a = exc_rdata;
				ops.mac_b = coef_data;
				ops.mac_c = r.s;
				r_nx.s = ops_res.mac_out;
				ops.add_a = r.x2;
				ops.add_b = r.i;
				exc_addr = ops_res.add_out[ADDR_W-1:0];	// x2[i]
				ops.ladd_a = acc_t'(r.c2);
				ops.ladd_b = acc_t'(r.k);
				coef_addr = ops_res.ladd_out[4:0];
				state_nx = TAP_POS;
			end
			TAP_POS:
			begin
				ops.mac_a = exc_rdata;
				ops.mac_b = coef_data;
				ops.mac_c = r.s;
				r_nx.s = ops_res.mac_out;
				ops.add_a = r.i;
				ops.add_b = 16'sd1;
				r_nx.i = ops_res.add_out;
				ops.ladd_a = acc_t'(r.k);
				ops.ladd_b = acc_t'(UP_SAMP);
				r_nx.k = ops_res.ladd_out[15:0];	// k += 3
				state_nx = TAP_ADDR;
			end
			NEXT_SAMPLE:
			begin
				ops.add_a = r.j;
				ops.add_b = 16'sd1;
				r_nx.j = ops_res.add_out;
				state_nx = SAMPLE;
			end
			default:
				state_nx = IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// protocol checks

	frac_folded: assert property (@(posedge clk) disable iff (reset)
		state == ADJUST |=> (r.frac1 >= 0 && r.frac1 <= 2));
	// the write follows the last tap and stays inside the subframe
	write_at_exit: assert property (@(posedge clk) disable iff (reset)
		exc_we |-> (state == TAP_ADDR && r.i == N_TAPS && r.j < len));
	done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pitch interpolation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/100ps \
	--top-module pitch_interp_tb \
	-Mdir obj_dir -o pitch_interp_sim \
	-f pitch_interp.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/pitch_interp_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: sim/pitch_interp_tb.sv
`default_nettype none

module pitch_interp_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pitch_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;
	localparam int TIMEOUT = 200;	// cycles per handshake
	localparam int POLL_LIMIT = 1000;	// CTRL reads per job
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// G.729 1/3 interpolation filter in Q15
	localparam int INTER [31] = '{
		29443, 25207, 14701, 3143, -4402, -5850, -2783, 1211, 3130, 2259, 0,
		-1652, -1666, -464, 756, 1099, 550, -245, -634, -451, 0, 308, 296, 78,
		-120, -165, -79, 34, 91, 70, 0
	};

	logic clk;
	logic reset;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int seed = 32'h176f4330;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int done_count = 0;
	int busy_cycles = 0;
	int shadow [DEPTH];	// expected buffer contents

	pitch_interp_top #(.ADDR_W(ADDR_W)) DUT (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		if (DUT.done)
			done_count++;
		if (DUT.busy)
			busy_cycles++;
	end

	//////////////////////////////////////////////////////////////////////
	// protocol checks

	r_held: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		errors++;
		$display("** Error @ %0t ns: read response changed while rready was low", $time);
	end

	b_held: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		errors++;
		$display("** Error @ %0t ns: write response changed while bready was low", $time);
	end

	start_when_idle: assert property (@(posedge clk) disable iff (reset)
		DUT.start |-> !DUT.busy)
	else
	begin
		errors++;
		$display("** Error @ %0t ns: engine started while busy", $time);
	end

	done_ends_job: assert property (@(posedge clk) disable iff (reset)
		DUT.done |=> !DUT.busy)
	else
	begin
		errors++;
		$display("** Error @ %0t ns: busy still high after done", $time);
	end

	//////////////////////////////////////////////////////////////////////
	// helpers

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		timeouts++;
		$display("timeout: no %s within the allowed number of cycles", what);
		finish_run();
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error @ %0t ns: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1;	// drive and sample away from the edge
	endtask

	function automatic logic [AXI_ADDR_W-1:0] window_addr(input int a);
		return EXC_WINDOW + AXI_ADDR_W'(a * 4);
	endfunction

	task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!(awready && wready) && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (!(awready && wready))
			timed_out("write address and data handshake");
		tick();	// handshake edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (!bvalid)
			timed_out("write response");
		check_eq("write response latency", 1, n + 1);
		resp = bresp;
		tick();	// bready stays low for one cycle
		bready = 1'b1;
		tick();
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp, input int hold);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (!arready)
			timed_out("read address handshake");
		tick();
		arvalid = 1'b0;
		rready = (hold == 0);
		n = 0;
		while (!rvalid && n < TIMEOUT)
		begin
			tick();
			n++;
		end
		if (!rvalid)
			timed_out("read response");
		check_eq("read response latency", 2, n + 1);
		data = rdata;
		resp = rresp;
		repeat (hold) tick();	// r_held watches the bus during back-pressure
		if (hold > 0)
		begin
			check_eq("held read data", data, rdata);
			rready = 1'b1;
		end
		tick();
		rready = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model of the interpolation

	function automatic int sat32(input longint v);
		if (v > 64'sd2147483647)
			return 2147483647;
		if (v < -64'sd2147483648)
			return -2147483647 - 1;
		return int'(v);
	endfunction

	function automatic int l_mac(input int acc, input int a, input int b);
		longint prod;
		prod = longint'(a) * longint'(b) * 2;
		if (prod > 64'sd2147483647)
			prod = 64'sd2147483647;	// -32768 squared
		return sat32(longint'(acc) + prod);
	endfunction

	task automatic model_interp(input int t0_v, input int frac_v, input int base_v,
		input int len_v);
		int x0;
		int x1;
		int x2;
		int f;
		int s;
		x0 = base_v - t0_v;
		f = -frac_v;
		if (f < 0)
		begin
			f += 3;
			x0--;
		end
		for (int j = 0; j < len_v; j++)
		begin
			x1 = x0;
			x0++;
			x2 = x0;
			s = 0;
			for (int i = 0; i < 10; i++)
			begin
				s = l_mac(s, shadow[(x1 - i) & (DEPTH - 1)], INTER[f + 3 * i]);
				s = l_mac(s, shadow[(x2 + i) & (DEPTH - 1)], INTER[3 - f + 3 * i]);
			end
			shadow[(base_v + j) & (DEPTH - 1)] = sat32(longint'(s) + 32768) >>> 16;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// buffer and job tasks

	task automatic fill_random();
		logic [31:0] w;
		logic [1:0] resp;
		sample_t s;
		for (int a = 0; a < DEPTH; a++)
		begin
			w = $random(seed);
			s = w[15:0];
			shadow[a] = s;
			axil_write(window_addr(a), w, resp);	// upper half is dropped
			check_eq("window write response", RESP_OKAY, resp);
		end
	endtask

	task automatic fill_const(input int v);
		logic [1:0] resp;
		for (int a = 0; a < DEPTH; a++)
		begin
			shadow[a] = v;
			axil_write(window_addr(a), v, resp);
			check_eq("window write response", RESP_OKAY, resp);
		end
	endtask

	task automatic check_buffer(input string what);
		logic [31:0] v;
		logic [1:0] resp;
		for (int a = 0; a < DEPTH; a++)
		begin
			axil_read(window_addr(a), v, resp, 0);
			check_eq($sformatf("%s word %0d", what, a), shadow[a], v);
			check_eq("window read response", RESP_OKAY, resp);
		end
	endtask

	task automatic set_job(input int t0_v, input int frac_v, input int base_v, input int len_v);
		logic [1:0] resp;
		axil_write(REG_T0, t0_v, resp);
		check_eq("T0 write response", RESP_OKAY, resp);
		axil_write(REG_FRAC, frac_v, resp);
		check_eq("FRAC write response", RESP_OKAY, resp);
		axil_write(REG_BASE, base_v, resp);
		check_eq("BASE write response", RESP_OKAY, resp);
		axil_write(REG_LEN, len_v, resp);
		check_eq("LEN write response", RESP_OKAY, resp);
	endtask

	task automatic start_job();
		logic [1:0] resp;
		axil_write(REG_CTRL, 32'h1, resp);
		check_eq("start write response", RESP_OKAY, resp);
	endtask

	task automatic wait_done();
		logic [31:0] v;
		logic [1:0] resp;
		int n;
		v = '0;
		n = 0;
		while (v[1:0] != 2'b10 && n < POLL_LIMIT)
		begin
			axil_read(REG_CTRL, v, resp, 0);
			n++;
		end
		if (v[1:0] != 2'b10)
			timed_out("done flag in CTRL");
		check_eq("CTRL after job", 32'h2, v);
	endtask

	task automatic run_and_check(input int t0_v, input int frac_v, input string what);
		int done_before;
		int busy_before;
		set_job(t0_v, frac_v, 100, 40);
		done_before = done_count;
		busy_before = busy_cycles;
		start_job();
		wait_done();
		check_eq("done pulses per job", 1, done_count - done_before);
		check_eq("busy cycles per job", 35 * 40 + 3, busy_cycles - busy_before);
		model_interp(t0_v, frac_v, 100, 40);
		check_buffer(what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		logic [31:0] v;
		logic [1:0] resp;
		int t0_v;
		int done_before;
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (3) tick();
		reset = 1'b0;
		check_eq("handshake outputs after reset", 5'b0,
			{awready, wready, arready, bvalid, rvalid});

		// registers come up cleared
		axil_read(REG_CTRL, v, resp, 0);
		check_eq("CTRL after reset", 32'h0, v);
		axil_read(REG_T0, v, resp, 0);
		check_eq("T0 after reset", 32'h0, v);
		axil_read(REG_LEN, v, resp, 0);
		check_eq("LEN after reset", 32'h0, v);

		set_job(45, -1, 100, 40);
		axil_read(REG_T0, v, resp, 0);
		check_eq("T0 read-back", 32'd45, v);
		axil_read(REG_FRAC, v, resp, 0);
		check_eq("FRAC read-back", 32'hffff_ffff, v);
		axil_read(REG_BASE, v, resp, 0);
		check_eq("BASE read-back", 32'd100, v);
		axil_read(REG_LEN, v, resp, 0);
		check_eq("LEN read-back", 32'd40, v);
		check_eq("register read response", RESP_OKAY, resp);

		fill_random();
		check_buffer("random fill");

		// one job per fraction
		for (int f = -1; f <= 1; f++)
		begin
			t0_v = 20 + ({$random(seed)} % 41);
			run_and_check(t0_v, f, $sformatf("frac %0d result", f));
		end

		fill_const(32767);
		run_and_check(30, 0, "positive saturation");
		fill_const(-32768);
		run_and_check(35, -1, "negative saturation");

		//////////////////////////////////////////////////////////////////
		// host accesses while a job runs

		fill_random();
		t0_v = 20 + ({$random(seed)} % 41);
		set_job(t0_v, 1, 100, 40);
		done_before = done_count;
		start_job();
		axil_read(REG_CTRL, v, resp, 0);
		check_eq("CTRL while busy", 32'h1, v);
		axil_read(window_addr(5), v, resp, 0);
		check_eq("window read response while busy", RESP_SLVERR, resp);
		check_eq("window read data while busy", 32'h0, v);
		axil_write(window_addr(105), 32'h1234, resp);
		check_eq("window write response while busy", RESP_SLVERR, resp);
		axil_write(REG_T0, 25, resp);
		axil_write(REG_CTRL, 32'h1, resp);	// second start
		check_eq("second start response", RESP_OKAY, resp);
		wait_done();
		check_eq("done pulses with second start", 1, done_count - done_before);
		axil_read(REG_T0, v, resp, 0);
		check_eq("T0 kept during job", t0_v, v);
		model_interp(t0_v, 1, 100, 40);
		check_buffer("locked job result");

		// slow host on the read channel
		axil_read(window_addr(7), v, resp, 6);
		check_eq("held window read", shadow[7], v);
		check_eq("held window read response", RESP_OKAY, resp);
		axil_read(REG_LEN, v, resp, 4);
		check_eq("held register read", 32'd40, v);

		finish_run();
	end

endmodule

`default_nettype wire
